// ==== verif/tap_cases.mem ====
// op chan enable count id base attr tready_pattern, all hex
// op 0 items on one channel, 1 fill all queues then release, 2 credit stall, 3 burst with AR/AW
// attr holds len in [7:0], size in [10:8], burst in [13:12], rresp in [17:16]
0 0 7 3 1 10000000 1203 ffffffff
0 1 7 3 5 20000040 0210 f0f0f0f0
0 2 7 6 3 a0000000 10000 ffffffff
0 2 7 8 7 b0000000 0 33333333
1 0 7 2 2 30000000 1100 ffffffff
1 0 7 4 9 40000000 2301 ffffffff
2 0 7 0 4 50000000 0203 ffffffff
2 1 7 0 6 60000000 0101 ffffffff
2 2 7 0 8 c0000000 20000 ffffffff
3 2 7 6 a d0000000 1205 11111111
3 2 7 10 b e0000000 30000 01010101
// channel enable masks, bit 0 AR, bit 1 AW, bit 2 R
0 0 6 3 c 70000000 1203 ffffffff
0 2 3 4 d f0000000 0 ffffffff
1 0 2 2 e 80000000 0201 ffffffff
3 2 3 5 f 90000000 0 ffffffff
f 0 0 0 0 0 0 0

// ==== vlog.f ====
source/axi_tap_pkg.sv
source/tap_links.sv
source/channel_capture.sv
source/channel_queue.sv
source/stream_merger.sv
source/axi_stream_tap.sv
verif/tb_axi_stream_tap.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_stream_tap
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_axi_stream_tap.sv ====
module tb_axi_stream_tap;

  localparam int max_cases   = 64;
  localparam int case_fields = 8;
  localparam int period      = 40;

  logic clk;
  logic resetn;
  logic [axi_tap_pkg::id_width-1:0]   sub_arid, mgr_arid, sub_awid, mgr_awid, sub_rid, mgr_rid;
  logic [axi_tap_pkg::addr_width-1:0] sub_araddr, mgr_araddr, sub_awaddr, mgr_awaddr;
  logic [axi_tap_pkg::len_width-1:0]  sub_arlen, mgr_arlen, sub_awlen, mgr_awlen;
  logic [2:0]                         sub_arsize, mgr_arsize, sub_awsize, mgr_awsize;
  logic [1:0]                         sub_arburst, mgr_arburst, sub_awburst, mgr_awburst;
  logic [1:0]                         sub_rresp, mgr_rresp;
  logic [axi_tap_pkg::data_width-1:0] sub_rdata, mgr_rdata;
  logic                               sub_arvalid, sub_arready, mgr_arvalid, mgr_arready;
  logic                               sub_awvalid, sub_awready, mgr_awvalid, mgr_awready;
  logic                               sub_rvalid, sub_rready, mgr_rvalid, mgr_rready;
  logic                               sub_rlast, mgr_rlast;
  logic [axi_tap_pkg::n_channels-1:0] channel_enable;
  logic [axi_tap_pkg::word_width-1:0] stream_tdata;
  logic                               stream_tlast, stream_tvalid, stream_tready;

  logic [31:0] case_mem [max_cases*case_fields];
  // expected stream words per channel, tlast kept above the word
  logic [axi_tap_pkg::word_width:0] exp_q [axi_tap_pkg::n_channels][$];
  string out_ready_name [axi_tap_pkg::n_channels] = '{"sub_arready", "sub_awready", "mgr_rready"};
  string in_ready_name [axi_tap_pkg::n_channels] = '{"mgr_arready", "mgr_awready", "sub_rready"};
  string out_valid_name [axi_tap_pkg::n_channels] = '{"mgr_arvalid", "mgr_awvalid", "sub_rvalid"};

  int          n_cases;
  int          errors;
  int          words;
  int          m_cur;
  logic        m_lock;
  logic [31:0] seed;
  logic [31:0] pattern;
  int          phase;
  logic        hold;
  logic        stall_off;
  logic [axi_tap_pkg::id_width-1:0] c_id;
  logic [31:0] c_base;
  logic [31:0] c_attr;

  axi_stream_tap uut (.*);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    errors++;
    $display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
  endtask

  function automatic logic handshake(input int ch);
    case (ch)
      axi_tap_pkg::chan_ar: return sub_arvalid && sub_arready;
      axi_tap_pkg::chan_aw: return sub_awvalid && sub_awready;
      default:              return mgr_rvalid && mgr_rready;
    endcase
  endfunction

  // the DUT output ready of a channel above the ready it passes on
  function automatic logic [1:0] ready_pair(input int ch);
    case (ch)
      axi_tap_pkg::chan_ar: return {sub_arready, mgr_arready};
      axi_tap_pkg::chan_aw: return {sub_awready, mgr_awready};
      default:              return {mgr_rready, sub_rready};
    endcase
  endfunction

  // the valid the DUT passes on above the valid it receives
  function automatic logic [1:0] valid_pair(input int ch);
    case (ch)
      axi_tap_pkg::chan_ar: return {mgr_arvalid, sub_arvalid};
      axi_tap_pkg::chan_aw: return {mgr_awvalid, sub_awvalid};
      default:              return {sub_rvalid, mgr_rvalid};
    endcase
  endfunction

  // starts at 2 after a rising edge and ends there once the beat has been taken
  task automatic drive_item(input int ch, input int idx, input logic last);
    logic done;
    case (ch)
      axi_tap_pkg::chan_ar: begin
        sub_arid    = c_id + axi_tap_pkg::id_width'(idx);
        sub_araddr  = c_base + 32'(idx * 16);
        sub_arlen   = c_attr[7:0];
        sub_arsize  = c_attr[10:8];
        sub_arburst = c_attr[13:12];
        sub_arvalid = 1'b1;
      end
      axi_tap_pkg::chan_aw: begin
        sub_awid    = c_id + axi_tap_pkg::id_width'(idx);
        sub_awaddr  = c_base + 32'(idx * 16);
        sub_awlen   = c_attr[7:0];
        sub_awsize  = c_attr[10:8];
        sub_awburst = c_attr[13:12];
        sub_awvalid = 1'b1;
      end
      default: begin
        mgr_rid    = c_id;
        mgr_rdata  = c_base + 32'(idx);
        mgr_rresp  = c_attr[17:16];
        mgr_rlast  = last;
        mgr_rvalid = 1'b1;
      end
    endcase
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = handshake(ch);
      @(posedge clk);
      #2;
    end
    case (ch)
      axi_tap_pkg::chan_ar: sub_arvalid = 1'b0;
      axi_tap_pkg::chan_aw: sub_awvalid = 1'b0;
      default:              mgr_rvalid  = 1'b0;
    endcase
  endtask

  // with burst set an R sequence is one burst, otherwise every beat is its own item
  task automatic issue_items(input int ch, input int n, input logic burst);
    for (int i = 0; i < n; i++) begin
      drive_item(ch, i, burst ? (i == n - 1) : 1'b1);
    end
  endtask

  task automatic check_backpressure(input int ch);
    stall_off = 1'b1;
    hold      = 1'b1;
    issue_items(ch, axi_tap_pkg::queue_depth, 1'b0);
    fork
      drive_item(ch, axi_tap_pkg::queue_depth, 1'b1);
      begin
        @(negedge clk);
        if (ready_pair(ch) !== 2'b01) begin
          report_mismatch({out_ready_name[ch], ",", in_ready_name[ch]}, 64'b01,
                          64'(ready_pair(ch)));
        end
        hold = 1'b0;
      end
    join
    stall_off = 1'b0;
  endtask

  // address handshakes land while the R burst is still going out
  task automatic burst_with_addresses(input int n);
    fork
      issue_items(axi_tap_pkg::chan_r, n, 1'b1);
      begin
        repeat (3) @(posedge clk);
        #2;
        issue_items(axi_tap_pkg::chan_ar, 1, 1'b0);
      end
      begin
        repeat (5) @(posedge clk);
        #2;
        issue_items(axi_tap_pkg::chan_aw, 1, 1'b0);
      end
    join
  endtask

  task automatic drain();
    hold    = 1'b0;
    pattern = '1;
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    #2;
  endtask

  // manager side ready stalls and the stream ready pattern
  initial begin
    forever begin
      @(posedge clk);
      #2;
      seed = lcg_next(seed);
      if (stall_off) begin
        mgr_arready = 1'b1;
        mgr_awready = 1'b1;
        sub_rready  = 1'b1;
      end else begin
        mgr_arready = seed[17:16] != 2'b00;
        mgr_awready = seed[20:19] != 2'b00;
        sub_rready  = seed[23:22] != 2'b00;
      end
      stream_tready = !hold && pattern[phase];
      phase = (phase + 1) % 32;
    end
  end

  // reference model, sampled mid cycle when every signal has settled
  always @(negedge clk) begin : model
    int                               sel;
    int                               c;
    logic                             found;
    logic                             exp_valid;
    logic [axi_tap_pkg::word_width:0] w;
    logic [1:0]                       vp;
    if (!resetn) begin
      if ({mgr_arid, mgr_araddr, mgr_arlen, mgr_arsize, mgr_arburst} !==
          {sub_arid, sub_araddr, sub_arlen, sub_arsize, sub_arburst}) begin
        report_mismatch("mgr_ar fields", {sub_arid, sub_araddr, sub_arlen, sub_arsize, sub_arburst},
                        {mgr_arid, mgr_araddr, mgr_arlen, mgr_arsize, mgr_arburst});
      end
      if ({mgr_awid, mgr_awaddr, mgr_awlen, mgr_awsize, mgr_awburst} !==
          {sub_awid, sub_awaddr, sub_awlen, sub_awsize, sub_awburst}) begin
        report_mismatch("mgr_aw fields", {sub_awid, sub_awaddr, sub_awlen, sub_awsize, sub_awburst},
                        {mgr_awid, mgr_awaddr, mgr_awlen, mgr_awsize, mgr_awburst});
      end
      if ({sub_rid, sub_rdata, sub_rresp, sub_rlast} !== {mgr_rid, mgr_rdata, mgr_rresp, mgr_rlast})
      begin
        report_mismatch("sub_r fields", {mgr_rid, mgr_rdata, mgr_rresp, mgr_rlast},
                        {sub_rid, sub_rdata, sub_rresp, sub_rlast});
      end

      // the credit gate on valid is certain only with a full queue or two free entries
      for (int k = 0; k < axi_tap_pkg::n_channels; k++) begin
        vp = valid_pair(k);
        if (!channel_enable[k] || exp_q[k].size() < axi_tap_pkg::queue_depth - 1) begin
          if (vp[1] !== vp[0]) begin
            report_mismatch(out_valid_name[k], 64'(vp[0]), 64'(vp[1]));
          end
        end else if (exp_q[k].size() == axi_tap_pkg::queue_depth) begin
          if (vp[1] !== 1'b0) begin
            report_mismatch(out_valid_name[k], 64'b0, 64'(vp[1]));
          end
        end
      end

      // round robin from one past the last served channel unless a burst holds the stream
      sel   = m_cur;
      found = 1'b0;
      if (!m_lock) begin
        for (int k = 1; k <= axi_tap_pkg::n_channels; k++) begin
          c = (m_cur + k) % axi_tap_pkg::n_channels;
          if (!found && exp_q[c].size() != 0) begin
            sel   = c;
            found = 1'b1;
          end
        end
      end
      exp_valid = exp_q[sel].size() != 0;
      if (stream_tvalid !== exp_valid) begin
        report_mismatch("stream_tvalid", 64'(exp_valid), 64'(stream_tvalid));
      end else if (exp_valid) begin
        w = exp_q[sel][0];
        if (stream_tdata !== w[axi_tap_pkg::word_width-1:0]) begin
          report_mismatch("stream_tdata", 64'(w[axi_tap_pkg::word_width-1:0]), 64'(stream_tdata));
        end
        if (stream_tlast !== w[axi_tap_pkg::word_width]) begin
          report_mismatch("stream_tlast", 64'(w[axi_tap_pkg::word_width]), 64'(stream_tlast));
        end
        if (stream_tready) begin
          void'(exp_q[sel].pop_front());
          m_cur  = sel;
          m_lock = !w[axi_tap_pkg::word_width];
          words++;
        end
      end

      // handshakes of this cycle reach the queues at the coming edge
      if (sub_arvalid && sub_arready && channel_enable[axi_tap_pkg::chan_ar]) begin
        exp_q[axi_tap_pkg::chan_ar].push_back({1'b1, axi_tap_pkg::chan_ar, sub_arid, sub_araddr,
                                               sub_arlen, sub_arsize, sub_arburst, 1'b0});
      end
      if (sub_awvalid && sub_awready && channel_enable[axi_tap_pkg::chan_aw]) begin
        exp_q[axi_tap_pkg::chan_aw].push_back({1'b1, axi_tap_pkg::chan_aw, sub_awid, sub_awaddr,
                                               sub_awlen, sub_awsize, sub_awburst, 1'b0});
      end
      if (mgr_rvalid && mgr_rready && channel_enable[axi_tap_pkg::chan_r]) begin
        exp_q[axi_tap_pkg::chan_r].push_back({mgr_rlast, axi_tap_pkg::chan_r, mgr_rid, mgr_rresp,
                                              mgr_rlast, mgr_rdata, 11'd0});
      end
    end
  end

  initial begin : watchdog
    wait (n_cases > 0);
    repeat (n_cases * 200 + 8) @(posedge clk);
    $display("timeout after %0d cycles with stream words still pending", n_cases * 200 + 8);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    int op;
    int ch;
    int cnt;
    int base;
    resetn         = 1'b1;
    channel_enable = '1;
    {sub_arid, sub_araddr, sub_arlen, sub_arsize, sub_arburst, sub_arvalid} = '0;
    {sub_awid, sub_awaddr, sub_awlen, sub_awsize, sub_awburst, sub_awvalid} = '0;
    {mgr_rid, mgr_rdata, mgr_rresp, mgr_rlast, mgr_rvalid} = '0;
    mgr_arready   = 1'b0;
    mgr_awready   = 1'b0;
    sub_rready    = 1'b0;
    stream_tready = 1'b0;
    seed          = 32'h8f2a;
    pattern       = '1;
    phase         = 0;
    hold          = 1'b0;
    stall_off     = 1'b0;
    errors        = 0;
    words         = 0;
    m_cur         = axi_tap_pkg::n_channels - 1;
    m_lock        = 1'b0;
    $readmemh("verif/tap_cases.mem", case_mem);
    while (n_cases < max_cases && case_mem[n_cases * case_fields] != 32'hf) begin
      n_cases++;
    end

    repeat (8) @(posedge clk);
    #2;
    resetn = 1'b0;

    for (int n = 0; n < n_cases; n++) begin
      base           = n * case_fields;
      op             = int'(case_mem[base]);
      ch             = int'(case_mem[base + 1]);
      channel_enable = case_mem[base + 2][axi_tap_pkg::n_channels-1:0];
      cnt            = int'(case_mem[base + 3]);
      c_id           = case_mem[base + 4][axi_tap_pkg::id_width-1:0];
      c_base         = case_mem[base + 5];
      c_attr         = case_mem[base + 6];
      pattern        = case_mem[base + 7];
      case (op)
        0: issue_items(ch, cnt, 1'b1);
        1: begin
          hold = 1'b1;
          for (int c = 0; c < axi_tap_pkg::n_channels; c++) begin
            issue_items(c, cnt, 1'b0);
          end
          hold = 1'b0;
        end
        2: check_backpressure(ch);
        default: burst_with_addresses(cnt);
      endcase
      drain();
    end

    $display("cases: %0d, stream words checked: %0d, errors: %0d", n_cases, words, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== source/axi_stream_tap.sv ====
module axi_stream_tap (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic [axi_tap_pkg::id_width-1:0]   sub_arid,
  input  logic [axi_tap_pkg::addr_width-1:0] sub_araddr,
  input  logic [axi_tap_pkg::len_width-1:0]  sub_arlen,
  input  logic [2:0]                         sub_arsize,
  input  logic [1:0]                         sub_arburst,
  input  logic                               sub_arvalid,
  output logic                               sub_arready,
  output logic [axi_tap_pkg::id_width-1:0]   mgr_arid,
  output logic [axi_tap_pkg::addr_width-1:0] mgr_araddr,
  output logic [axi_tap_pkg::len_width-1:0]  mgr_arlen,
  output logic [2:0]                         mgr_arsize,
  output logic [1:0]                         mgr_arburst,
  output logic                               mgr_arvalid,
  input  logic                               mgr_arready,
  input  logic [axi_tap_pkg::id_width-1:0]   sub_awid,
  input  logic [axi_tap_pkg::addr_width-1:0] sub_awaddr,
  input  logic [axi_tap_pkg::len_width-1:0]  sub_awlen,
  input  logic [2:0]                         sub_awsize,
  input  logic [1:0]                         sub_awburst,
  input  logic                               sub_awvalid,
  output logic                               sub_awready,
  output logic [axi_tap_pkg::id_width-1:0]   mgr_awid,
  output logic [axi_tap_pkg::addr_width-1:0] mgr_awaddr,
  output logic [axi_tap_pkg::len_width-1:0]  mgr_awlen,
  output logic [2:0]                         mgr_awsize,
  output logic [1:0]                         mgr_awburst,
  output logic                               mgr_awvalid,
  input  logic                               mgr_awready,
  input  logic [axi_tap_pkg::id_width-1:0]   mgr_rid,
  input  logic [axi_tap_pkg::data_width-1:0] mgr_rdata,
  input  logic [1:0]                         mgr_rresp,
  input  logic                               mgr_rlast,
  input  logic                               mgr_rvalid,
  output logic                               mgr_rready,
  output logic [axi_tap_pkg::id_width-1:0]   sub_rid,
  output logic [axi_tap_pkg::data_width-1:0] sub_rdata,
  output logic [1:0]                         sub_rresp,
  output logic                               sub_rlast,
  output logic                               sub_rvalid,
  input  logic                               sub_rready,
  input  logic [axi_tap_pkg::n_channels-1:0] channel_enable,
  output logic [axi_tap_pkg::word_width-1:0] stream_tdata,
  output logic                               stream_tlast,
  output logic                               stream_tvalid,
  input  logic                               stream_tready
);

  tap_link_if   links [axi_tap_pkg::n_channels] ();
  queue_head_if heads [axi_tap_pkg::n_channels] ();

  // AXI ports share their names with the capture stage
  channel_capture u_capture (
    .links (links),
    .*
  );

  for (genvar g = 0; g < axi_tap_pkg::n_channels; g++) begin : g_queue
    channel_queue u_queue (
      .clk    (clk),
      .resetn (resetn),
      .link   (links[g]),
      .head   (heads[g])
    );
  end

  stream_merger u_merger (
    .heads (heads),
    .*
  );

endmodule

// ==== source/stream_merger.sv ====
module stream_merger (
  input  logic                               clk,
  input  logic                               resetn,
  queue_head_if.merger                       heads [axi_tap_pkg::n_channels],
  output logic [axi_tap_pkg::word_width-1:0] stream_tdata,
  output logic                               stream_tlast,
  output logic                               stream_tvalid,
  input  logic                               stream_tready
);

  logic [axi_tap_pkg::n_channels-1:0] head_valid;
  logic [axi_tap_pkg::n_channels-1:0] head_last;
  axi_tap_pkg::stream_word_u          head_word [axi_tap_pkg::n_channels];

  logic [axi_tap_pkg::chan_bits-1:0] cur;
  logic [axi_tap_pkg::chan_bits-1:0] sel;
  logic                              lock;
  logic                              xfer;

  for (genvar g = 0; g < axi_tap_pkg::n_channels; g++) begin : g_head
    assign head_valid[g] = heads[g].valid;
    assign head_last[g]  = heads[g].last;
    assign head_word[g]  = heads[g].word;
    assign heads[g].pop  = xfer && (sel == g);
  end

  // start searching one past the last served channel, wrapping back to it last
  always_comb begin
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    sel   = cur;
    if (!lock) begin
      for (int k = 1; k <= axi_tap_pkg::n_channels; k++) begin
        idx = (int'(cur) + k) % axi_tap_pkg::n_channels;
        if (!found && head_valid[idx]) begin
          sel   = axi_tap_pkg::chan_bits'(idx);
          found = 1'b1;
        end
      end
    end
  end

  assign stream_tvalid = head_valid[sel];
  assign stream_tdata  = head_word[sel];
  assign stream_tlast  = head_last[sel];
  assign xfer          = stream_tvalid && stream_tready;

  always_ff @(posedge clk) begin
    if (resetn) begin
      // so that AR gets the first turn after reset
      cur  <= axi_tap_pkg::chan_bits'(axi_tap_pkg::n_channels - 1);
      lock <= 1'b0;
    end else if (xfer) begin
      cur  <= sel;
      lock <= !stream_tlast;
    end
  end

  // a burst keeps the stream until its final beat has gone out
  a_burst_hold: assert property (@(posedge clk) disable iff (resetn)
    (lock && !(xfer && stream_tlast)) |=> lock && (sel == $past(sel)));

endmodule

// ==== source/channel_queue.sv ====
module channel_queue (
  input  logic        clk,
  input  logic        resetn,
  tap_link_if.queue   link,
  queue_head_if.queue head
);

  axi_tap_pkg::stream_word_u mem_word [axi_tap_pkg::queue_depth];
  logic                      mem_last [axi_tap_pkg::queue_depth];

  // pointers carry one wrap bit above the entry index
  logic [axi_tap_pkg::credit_bits-1:0] wr_ptr;
  logic [axi_tap_pkg::credit_bits-1:0] rd_ptr;
  logic                                full;
  logic                                empty;
  logic                                credit_q;

  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[axi_tap_pkg::credit_bits-1] != rd_ptr[axi_tap_pkg::credit_bits-1])
              && (wr_ptr[axi_tap_pkg::credit_bits-2:0] == rd_ptr[axi_tap_pkg::credit_bits-2:0]);

  assign head.valid  = !empty;
  assign head.word   = mem_word[rd_ptr[axi_tap_pkg::credit_bits-2:0]];
  assign head.last   = mem_last[rd_ptr[axi_tap_pkg::credit_bits-2:0]];
  assign link.credit = credit_q;

  always_ff @(posedge clk) begin
    if (link.push) begin
      mem_word[wr_ptr[axi_tap_pkg::credit_bits-2:0]] <= link.word;
      mem_last[wr_ptr[axi_tap_pkg::credit_bits-2:0]] <= link.last;
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      credit_q <= 1'b0;
    end else begin
      if (link.push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (head.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // the freed entry goes back to the capture stage one cycle after the pop
      credit_q <= head.pop;
    end
  end

  // capture only pushes against credit, so a full queue means lost accounting
  a_no_overflow: assert property (@(posedge clk) disable iff (resetn)
    link.push |-> !full);

  a_no_underflow: assert property (@(posedge clk) disable iff (resetn)
    head.pop |-> !empty);

endmodule

// ==== source/channel_capture.sv ====
module channel_capture (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic [axi_tap_pkg::id_width-1:0]   sub_arid,
  input  logic [axi_tap_pkg::addr_width-1:0] sub_araddr,
  input  logic [axi_tap_pkg::len_width-1:0]  sub_arlen,
  input  logic [2:0]                         sub_arsize,
  input  logic [1:0]                         sub_arburst,
  input  logic                               sub_arvalid,
  output logic                               sub_arready,
  output logic [axi_tap_pkg::id_width-1:0]   mgr_arid,
  output logic [axi_tap_pkg::addr_width-1:0] mgr_araddr,
  output logic [axi_tap_pkg::len_width-1:0]  mgr_arlen,
  output logic [2:0]                         mgr_arsize,
  output logic [1:0]                         mgr_arburst,
  output logic                               mgr_arvalid,
  input  logic                               mgr_arready,
  input  logic [axi_tap_pkg::id_width-1:0]   sub_awid,
  input  logic [axi_tap_pkg::addr_width-1:0] sub_awaddr,
  input  logic [axi_tap_pkg::len_width-1:0]  sub_awlen,
  input  logic [2:0]                         sub_awsize,
  input  logic [1:0]                         sub_awburst,
  input  logic                               sub_awvalid,
  output logic                               sub_awready,
  output logic [axi_tap_pkg::id_width-1:0]   mgr_awid,
  output logic [axi_tap_pkg::addr_width-1:0] mgr_awaddr,
  output logic [axi_tap_pkg::len_width-1:0]  mgr_awlen,
  output logic [2:0]                         mgr_awsize,
  output logic [1:0]                         mgr_awburst,
  output logic                               mgr_awvalid,
  input  logic                               mgr_awready,
  input  logic [axi_tap_pkg::id_width-1:0]   mgr_rid,
  input  logic [axi_tap_pkg::data_width-1:0] mgr_rdata,
  input  logic [1:0]                         mgr_rresp,
  input  logic                               mgr_rlast,
  input  logic                               mgr_rvalid,
  output logic                               mgr_rready,
  output logic [axi_tap_pkg::id_width-1:0]   sub_rid,
  output logic [axi_tap_pkg::data_width-1:0] sub_rdata,
  output logic [1:0]                         sub_rresp,
  output logic                               sub_rlast,
  output logic                               sub_rvalid,
  input  logic                               sub_rready,
  input  logic [axi_tap_pkg::n_channels-1:0] channel_enable,
  tap_link_if.capture                        links [axi_tap_pkg::n_channels]
);

  // high when the channel may hand over a beat this cycle
  logic [axi_tap_pkg::n_channels-1:0] gate;
  logic [axi_tap_pkg::n_channels-1:0] fire;
  logic [axi_tap_pkg::n_channels-1:0] word_last;
  axi_tap_pkg::stream_word_u          words [axi_tap_pkg::n_channels];

  function automatic axi_tap_pkg::stream_word_u pack_addr(
    input logic [axi_tap_pkg::chan_bits-1:0]  chan,
    input logic [axi_tap_pkg::id_width-1:0]   id,
    input logic [axi_tap_pkg::addr_width-1:0] addr,
    input logic [axi_tap_pkg::len_width-1:0]  len,
    input logic [2:0]                         size,
    input logic [1:0]                         burst
  );
    axi_tap_pkg::stream_word_u w;
    w.addr_view.chan_type = chan;
    w.addr_view.id        = id;
    w.addr_view.addr      = addr;
    w.addr_view.len       = len;
    w.addr_view.size      = size;
    w.addr_view.burst     = burst;
    w.addr_view.pad       = 1'b0;
    return w;
  endfunction

  // address and read data fields pass straight through
  assign mgr_arid    = sub_arid;
  assign mgr_araddr  = sub_araddr;
  assign mgr_arlen   = sub_arlen;
  assign mgr_arsize  = sub_arsize;
  assign mgr_arburst = sub_arburst;
  assign mgr_awid    = sub_awid;
  assign mgr_awaddr  = sub_awaddr;
  assign mgr_awlen   = sub_awlen;
  assign mgr_awsize  = sub_awsize;
  assign mgr_awburst = sub_awburst;
  assign sub_rid     = mgr_rid;
  assign sub_rdata   = mgr_rdata;
  assign sub_rresp   = mgr_rresp;
  assign sub_rlast   = mgr_rlast;

  // both sides of each handshake see the credit gate, so a stalled beat never fires
  assign mgr_arvalid = sub_arvalid && gate[axi_tap_pkg::chan_ar];
  assign sub_arready = mgr_arready && gate[axi_tap_pkg::chan_ar];
  assign mgr_awvalid = sub_awvalid && gate[axi_tap_pkg::chan_aw];
  assign sub_awready = mgr_awready && gate[axi_tap_pkg::chan_aw];
  assign sub_rvalid  = mgr_rvalid && gate[axi_tap_pkg::chan_r];
  assign mgr_rready  = sub_rready && gate[axi_tap_pkg::chan_r];

  assign fire[axi_tap_pkg::chan_ar] = sub_arvalid && sub_arready;
  assign fire[axi_tap_pkg::chan_aw] = sub_awvalid && sub_awready;
  assign fire[axi_tap_pkg::chan_r]  = mgr_rvalid && mgr_rready;

  assign words[axi_tap_pkg::chan_ar] = pack_addr(axi_tap_pkg::chan_ar, sub_arid, sub_araddr,
                                                 sub_arlen, sub_arsize, sub_arburst);
  assign words[axi_tap_pkg::chan_aw] = pack_addr(axi_tap_pkg::chan_aw, sub_awid, sub_awaddr,
                                                 sub_awlen, sub_awsize, sub_awburst);

  always_comb begin
    words[axi_tap_pkg::chan_r].data_view.chan_type = axi_tap_pkg::chan_r;
    words[axi_tap_pkg::chan_r].data_view.id        = mgr_rid;
    words[axi_tap_pkg::chan_r].data_view.resp      = mgr_rresp;
    words[axi_tap_pkg::chan_r].data_view.last      = mgr_rlast;
    words[axi_tap_pkg::chan_r].data_view.data      = mgr_rdata;
    words[axi_tap_pkg::chan_r].data_view.pad       = '0;
  end

  // an address beat is a whole item on its own
  assign word_last[axi_tap_pkg::chan_ar] = 1'b1;
  assign word_last[axi_tap_pkg::chan_aw] = 1'b1;
  assign word_last[axi_tap_pkg::chan_r]  = mgr_rlast;

  for (genvar g = 0; g < axi_tap_pkg::n_channels; g++) begin : g_link
    logic [axi_tap_pkg::credit_bits-1:0] credits;

    // a disabled channel is not recorded and never waits for credit
    assign gate[g]        = !channel_enable[g] || (credits != '0);
    assign links[g].push  = fire[g] && channel_enable[g];
    assign links[g].word  = words[g];
    assign links[g].last  = word_last[g];

    always_ff @(posedge clk) begin
      if (resetn) begin
        credits <= axi_tap_pkg::credit_bits'(axi_tap_pkg::queue_depth);
      end else begin
        credits <= credits - axi_tap_pkg::credit_bits'(links[g].push)
                           + axi_tap_pkg::credit_bits'(links[g].credit);
      end
    end

    // credits returned by the queue can never exceed the entries it holds
    a_credit_bound: assert property (@(posedge clk) disable iff (resetn)
      credits <= axi_tap_pkg::credit_bits'(axi_tap_pkg::queue_depth));

    a_push_credit: assert property (@(posedge clk) disable iff (resetn)
      links[g].push |-> credits != '0);
  end

endmodule

// ==== source/tap_links.sv ====
// capture side to one per-channel queue, credits flow back
interface tap_link_if;
  logic                      push;
  axi_tap_pkg::stream_word_u word;
  logic                      last;
  logic                      credit;

  modport capture (
    output push,
    output word,
    output last,
    input  credit
  );

  modport queue (
    input  push,
    input  word,
    input  last,
    output credit
  );
endinterface

// oldest entry of a queue as seen by the merger
interface queue_head_if;
  logic                      valid;
  axi_tap_pkg::stream_word_u word;
  logic                      last;
  logic                      pop;

  modport queue (
    output valid,
    output word,
    output last,
    input  pop
  );

  modport merger (
    input  valid,
    input  word,
    input  last,
    output pop
  );
endinterface

// ==== source/axi_tap_pkg.sv ====
package axi_tap_pkg;

  localparam int id_width   = 4;
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int len_width  = 8;

  localparam int n_channels = 3;
  localparam int chan_bits  = 2;

  // channel indices, also carried as the type code of every stream word
  localparam logic [chan_bits-1:0] chan_ar = 2'd0;
  localparam logic [chan_bits-1:0] chan_aw = 2'd1;
  localparam logic [chan_bits-1:0] chan_r  = 2'd2;

  // one credit per queue entry, counters need one bit more than the index
  localparam int queue_depth = 4;
  localparam int credit_bits = 3;

  localparam int word_width = 52;

  typedef struct packed {
    logic [chan_bits-1:0]  chan_type;
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic                  pad;
  } addr_view_t;

  typedef struct packed {
    logic [chan_bits-1:0]  chan_type;
    logic [id_width-1:0]   id;
    logic [1:0]            resp;
    logic                  last;
    logic [data_width-1:0] data;
    logic [10:0]           pad;
  } data_view_t;

  // chan_type sits in the top bits of both views and selects the one to decode
  typedef union packed {
    addr_view_t addr_view;
    data_view_t data_view;
  } stream_word_u;

endpackage
